//--- logic/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;                // data word, address, pc
    typedef logic [4:0]  reg_addr_t;            // register file index

    localparam int        DMEM_WORDS  = 256;    // data memory depth in words
    localparam int        DMEM_ADDR_W = 8;      // width of a word index
    localparam reg_addr_t LINK_REG    = 5'd31;  // link instructions write pc+4 here

    // a is the rs operand, b is rt or the immediate
    typedef enum logic [3:0] {
        alu_add,                                // a + b
        alu_sub,                                // a - b
        alu_and,                                // a & b
        alu_or,                                 // a | b
        alu_xor,                                // a ^ b
        alu_slt,                                // signed a < b gives 1
        alu_sll,                                // a << b[4:0]
        alu_srl,                                // a >> b[4:0], zero fill
        alu_lui,                                // b << 16
        alu_pass_b                              // b unchanged
    } alu_op_t;

endpackage

//--- logic/pipe_pkg.sv
package pipe_pkg;

    // decoded instruction handed over by decode
    typedef struct packed {
        logic                no_op;             // bubble, nothing to do
        isa_pkg::alu_op_t    alu_op;
        isa_pkg::reg_addr_t  rs_addr;
        isa_pkg::reg_addr_t  rt_addr;
        isa_pkg::word_t      rs_val;            // as read from the register file, may be stale
        isa_pkg::word_t      rt_val;
        isa_pkg::word_t      imm;               // already extended to a word
        logic                use_imm;           // imm replaces rt as operand b
        isa_pkg::reg_addr_t  dest;
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
        logic                link;              // writeback is pc_4 into LINK_REG
        isa_pkg::word_t      pc_4;
    } ex_bundle_t;

    // contents of the ex/mem register
    typedef struct packed {
        logic                no_op;
        isa_pkg::word_t      pc_4;
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
        logic                link;
        isa_pkg::word_t      alu_result;        // also the memory byte address
        isa_pkg::word_t      store_data;
        isa_pkg::reg_addr_t  dest;
    } mem_bundle_t;

    // register write leaving the pipe
    typedef struct packed {
        logic                valid;
        isa_pkg::reg_addr_t  dest;
        isa_pkg::word_t      data;
    } wb_bundle_t;

    typedef enum logic [1:0] {
        from_input,                             // value carried in the ex bundle
        from_mem_result,                        // writeback value of the mem stage
        from_wb_data                            // data on the wb port
    } forw_sel_t;

    typedef struct packed {
        logic hold;                             // ex/mem keeps its contents
        logic no_op;                            // a bubble enters mem
    } hazard_ctrl_t;

endpackage

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  pipe_pkg::ex_bundle_t ex,
    input  pipe_pkg::forw_sel_t  rs_sel,
    input  pipe_pkg::forw_sel_t  rt_sel,
    input  isa_pkg::word_t       mem_result,    // writeback value sitting in mem
    input  isa_pkg::word_t       wb_data,       // value on the wb port
    output isa_pkg::word_t       result,
    output isa_pkg::word_t       rt_fwd         // fresh rt, store data
);

    isa_pkg::word_t op_a;
    isa_pkg::word_t op_b;

    always_comb begin
        case (rs_sel)
            pipe_pkg::from_mem_result: op_a = mem_result;
            pipe_pkg::from_wb_data:    op_a = wb_data;
            default:                   op_a = ex.rs_val;
        endcase
        case (rt_sel)
            pipe_pkg::from_mem_result: rt_fwd = mem_result;
            pipe_pkg::from_wb_data:    rt_fwd = wb_data;
            default:                   rt_fwd = ex.rt_val;
        endcase
    end

    assign op_b = ex.use_imm ? ex.imm : rt_fwd;     // i-type uses the immediate

    always_comb begin
        case (ex.alu_op)
            isa_pkg::alu_add:    result = op_a + op_b;
            isa_pkg::alu_sub:    result = op_a - op_b;
            isa_pkg::alu_and:    result = op_a & op_b;
            isa_pkg::alu_or:     result = op_a | op_b;
            isa_pkg::alu_xor:    result = op_a ^ op_b;
            isa_pkg::alu_slt:    result = {31'd0, $signed(op_a) < $signed(op_b)};
            isa_pkg::alu_sll:    result = op_a << op_b[4:0];    // shift amount from b
            isa_pkg::alu_srl:    result = op_a >> op_b[4:0];
            isa_pkg::alu_lui:    result = {op_b[15:0], 16'd0};
            isa_pkg::alu_pass_b: result = op_b;
            default:             result = '0;
        endcase
    end

endmodule

//--- logic/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit (
    input  pipe_pkg::ex_bundle_t  ex,
    input  pipe_pkg::mem_bundle_t mem,
    input  pipe_pkg::wb_bundle_t  wb,
    output pipe_pkg::forw_sel_t   rs_sel,
    output pipe_pkg::forw_sel_t   rt_sel
);

    isa_pkg::reg_addr_t mem_dest;               // register mem will really write
    logic               mem_writes;
    logic               wb_writes;

    assign mem_dest   = mem.link ? isa_pkg::LINK_REG : mem.dest;
    assign mem_writes = mem.reg_write && !mem.no_op && (mem_dest != '0);
    assign wb_writes  = wb.valid && (wb.dest != '0);    // r0 never forwards

    // youngest producer wins, so mem before wb
    function automatic pipe_pkg::forw_sel_t pick(input isa_pkg::reg_addr_t src);
        pipe_pkg::forw_sel_t sel;
        sel = pipe_pkg::from_input;
        if (mem_writes && (mem_dest == src))
            sel = pipe_pkg::from_mem_result;
        else if (wb_writes && (wb.dest == src))
            sel = pipe_pkg::from_wb_data;
        return sel;
    endfunction

    always_comb begin
        rs_sel = pick(ex.rs_addr);
        rt_sel = pick(ex.rt_addr);          // also used for store data
    end

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  pipe_pkg::ex_bundle_t   ex,
    input  pipe_pkg::mem_bundle_t  mem,
    input  logic                   freeze,  // memory wait
    output pipe_pkg::hazard_ctrl_t ctrl,
    output logic                   stall    // to the source, hold ex bundle
);

    logic load_in_mem;
    logic rs_hit;
    logic rt_hit;
    logic load_use;

    assign load_in_mem = mem.mem_read && !mem.no_op && mem.reg_write && (mem.dest != '0);
    assign rs_hit      = mem.dest == ex.rs_addr;
    // rt only counts when it is read as operand or store data
    assign rt_hit      = (mem.dest == ex.rt_addr) && (!ex.use_imm || ex.mem_write);
    assign load_use    = load_in_mem && (rs_hit || rt_hit);

    assign stall      = freeze || load_use;
    assign ctrl.hold  = freeze;                 // freeze keeps ex/mem as is
    assign ctrl.no_op = load_use && !freeze;    // bubble behind the load

endmodule

//--- logic/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pipe_pkg::hazard_ctrl_t ctrl,        // from hazard_unit
    input  pipe_pkg::ex_bundle_t   ex,
    input  isa_pkg::word_t         alu_result,
    input  pipe_pkg::forw_sel_t    store_sel,   // from forwarding_unit, rt select
    input  isa_pkg::word_t         wb_data,     // wb port data
    output pipe_pkg::mem_bundle_t  mem,
    output isa_pkg::word_t         fwd_value    // writeback value of this stage
);

    isa_pkg::word_t store_next;

    assign fwd_value = mem.link ? mem.pc_4 : mem.alu_result;   // link forwards pc+4

    always_comb begin
        case (store_sel)
            pipe_pkg::from_mem_result: store_next = fwd_value;  // result of previous ex
            pipe_pkg::from_wb_data:    store_next = wb_data;
            default:                   store_next = ex.rt_val;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem       <= '0;
            mem.no_op <= 1'b1;                      // empty stage reads as bubble
        end else if (!ctrl.hold) begin              // hold leaves everything in place
            mem.no_op      <= ctrl.no_op || ex.no_op;
            mem.pc_4       <= ex.pc_4;
            mem.reg_write  <= ex.reg_write;
            mem.mem_read   <= ex.mem_read;
            mem.mem_write  <= ex.mem_write;
            mem.link       <= ex.link;
            mem.alu_result <= alu_result;
            mem.store_data <= store_next;
            mem.dest       <= ex.dest;
        end
    end

endmodule

//--- logic/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                  clk,
    input  pipe_pkg::mem_bundle_t mem,
    input  logic                  freeze,
    output isa_pkg::word_t        load_data
);

    isa_pkg::word_t                   ram [isa_pkg::DMEM_WORDS];
    logic [isa_pkg::DMEM_ADDR_W-1:0]  word_idx;
    logic                             wr_en;

    // byte address, low two bits dropped
    assign word_idx = mem.alu_result[isa_pkg::DMEM_ADDR_W+1:2];

    // frozen entry stays in mem, so write only once it moves on
    assign wr_en = mem.mem_write && !mem.no_op && !freeze;

    always_ff @(posedge clk) begin
        if (wr_en)
            ram[word_idx] <= mem.store_data;
    end

    assign load_data = ram[word_idx];       // async read

endmodule

//--- logic/mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pipe_pkg::mem_bundle_t mem,
    input  isa_pkg::word_t        load_data,    // from data_mem
    input  logic                  freeze,
    output pipe_pkg::wb_bundle_t  wb
);

    isa_pkg::reg_addr_t wb_dest;
    isa_pkg::word_t     wb_value;
    logic               wb_valid;

    assign wb_dest = mem.link ? isa_pkg::LINK_REG : mem.dest;

    always_comb begin
        if (mem.link)
            wb_value = mem.pc_4;                // return address
        else if (mem.mem_read)
            wb_value = load_data;
        else
            wb_value = mem.alu_result;
    end

    // frozen entry is retired later, bubble now. r0 writes are dropped
    assign wb_valid = !freeze && !mem.no_op && mem.reg_write && (wb_dest != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= wb_valid;
            wb.dest  <= wb_dest;
            wb.data  <= wb_value;
        end
    end

endmodule

//--- logic/exec_backend.sv
`timescale 1ns/1ps

module exec_backend (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pipe_pkg::ex_bundle_t ex_in,     // decoded instruction from decode
    input  logic                 freeze,    // memory wait
    output logic                 stall,     // source must hold ex_in
    output pipe_pkg::wb_bundle_t wb_out     // retiring register write
);

    pipe_pkg::forw_sel_t    rs_sel;
    pipe_pkg::forw_sel_t    rt_sel;
    pipe_pkg::hazard_ctrl_t hz_ctrl;
    pipe_pkg::mem_bundle_t  mem_q;
    isa_pkg::word_t         alu_result;
    isa_pkg::word_t         fwd_value;
    isa_pkg::word_t         load_data;

    forwarding_unit fwd0 (
        .ex     (ex_in),
        .mem    (mem_q),
        .wb     (wb_out),
        .rs_sel (rs_sel),
        .rt_sel (rt_sel)
    );

    hazard_unit hz0 (
        .ex     (ex_in),
        .mem    (mem_q),
        .freeze (freeze),
        .ctrl   (hz_ctrl),
        .stall  (stall)
    );

    alu alu0 (
        .ex         (ex_in),
        .rs_sel     (rs_sel),
        .rt_sel     (rt_sel),
        .mem_result (fwd_value),
        .wb_data    (wb_out.data),
        .result     (alu_result),
        .rt_fwd     ()              // store data is forwarded inside exm0
    );

    ex_mem_reg exm0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (hz_ctrl),
        .ex         (ex_in),
        .alu_result (alu_result),
        .store_sel  (rt_sel),
        .wb_data    (wb_out.data),
        .mem        (mem_q),
        .fwd_value  (fwd_value)
    );

    data_mem dmem0 (
        .clk       (clk),
        .mem       (mem_q),
        .freeze    (freeze),
        .load_data (load_data)
    );

    mem_wb_reg mwb0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem       (mem_q),
        .load_data (load_data),
        .freeze    (freeze),
        .wb        (wb_out)
    );

endmodule

//--- testbench/tb_exec_backend.sv
`timescale 1ns/1ps

module tb_exec_backend;

    localparam int STALL_LIMIT = 8;             // cycles one bundle may wait on stall
    localparam int DRAIN_LIMIT = 40;            // cycles to collect the last writebacks

    logic                 clk;
    logic                 rst_n;
    pipe_pkg::ex_bundle_t ex_in;
    logic                 freeze;
    logic                 stall;
    pipe_pkg::wb_bundle_t wb_out;

    pipe_pkg::ex_bundle_t instr_q[$];           // stimulus in program order
    int                   freeze_q[$];          // freeze cycles before each bundle
    int                   stalls_q[$];          // expected load-use stall cycles
    pipe_pkg::wb_bundle_t exp_q[$];             // expected writebacks, retirement order
    pipe_pkg::wb_bundle_t got_q[$];             // writebacks seen on wb_out
    int                   store_count;          // stores in the stimulus
    int                   write_count;          // data memory write cycles seen

    exec_backend dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_in  (ex_in),
        .freeze (freeze),
        .stall  (stall),
        .wb_out (wb_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    task automatic fail_now();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic read_golden();
        int                   fd;
        int                   n;
        int                   fz;
        int                   st;
        byte                  tag;
        logic [8*256-1:0]     rest;             // remainder of a comment line
        logic [3:0]           op;
        logic [4:0]           rs;
        logic [4:0]           rt;
        logic [4:0]           dst;
        logic [31:0]          rs_val;
        logic [31:0]          rt_val;
        logic [31:0]          imm;
        logic [31:0]          pc_4;
        logic [31:0]          data;
        logic                 use_imm;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic                 link;
        pipe_pkg::ex_bundle_t b;
        pipe_pkg::wb_bundle_t w;
        fd = $fopen("testbench/backend_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/backend_golden.txt");
            fail_now();
        end
        store_count = 0;
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1)
                break;                          // only whitespace left
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "i") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %d %d",
                            op, rs, rt, rs_val, rt_val, imm, use_imm, dst,
                            reg_write, mem_read, mem_write, link, pc_4, fz, st);
                if (n != 15) begin
                    $display("instruction line %0d in the golden file is malformed",
                             instr_q.size());
                    fail_now();
                end
                b           = '0;               // no_op stays low
                b.alu_op    = isa_pkg::alu_op_t'(op);
                b.rs_addr   = rs;
                b.rt_addr   = rt;
                b.rs_val    = rs_val;           // may be stale on purpose
                b.rt_val    = rt_val;
                b.imm       = imm;
                b.use_imm   = use_imm;
                b.dest      = dst;
                b.reg_write = reg_write;
                b.mem_read  = mem_read;
                b.mem_write = mem_write;
                b.link      = link;
                b.pc_4      = pc_4;
                instr_q.push_back(b);
                freeze_q.push_back(fz);
                stalls_q.push_back(st);
                if (mem_write)
                    store_count++;
            end else if (tag == "e") begin
                n = $fscanf(fd, "%h %h", dst, data);
                if (n != 2) begin
                    $display("writeback line %0d in the golden file is malformed",
                             exp_q.size());
                    fail_now();
                end
                w.valid = 1'b1;
                w.dest  = dst;
                w.data  = data;
                exp_q.push_back(w);
            end else begin
                $display("unknown record type %c in the golden file", tag);
                fail_now();
            end
        end
        $fclose(fd);
    endtask

    // drive one bundle, with freeze ahead of it, until it is consumed
    task automatic issue_instr(input int idx);
        int f;
        int stalls;
        ex_in = instr_q[idx];
        for (f = 0; f < freeze_q[idx]; f++) begin
            freeze = 1'b1;
            @(negedge clk);
            compare_word("stall", 32'(stall), 32'd1);     // freeze holds the source
            @(posedge clk);
            #1;
        end
        freeze = 1'b0;
        stalls = 0;
        @(negedge clk);
        while (stall) begin
            stalls++;
            if (stalls > STALL_LIMIT) begin
                $display("instruction %0d was never accepted, stall stayed high", idx);
                fail_now();
            end
            @(negedge clk);
        end
        compare_word("stall cycles", 32'(stalls), 32'(stalls_q[idx]));
        @(posedge clk);                         // consumed at this edge
        #1;
    endtask

    // wb_out and the write enable are stable mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_out.valid)
                got_q.push_back(wb_out);
            if (dut0.dmem0.wr_en)
                write_count++;
        end
    end

    initial begin
        int i;
        int wait_cycles;
        rst_n       = 1'b0;
        freeze      = 1'b0;
        ex_in       = '0;
        ex_in.no_op = 1'b1;                     // bubble until the program starts
        write_count = 0;
        read_golden();
        repeat (15) @(posedge clk);
        @(negedge clk);
        compare_word("stall", 32'(stall), 32'd0);
        compare_word("wb_out.valid", 32'(wb_out.valid), 32'd0);
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (i = 0; i < instr_q.size(); i++)
            issue_instr(i);
        ex_in       = '0;
        ex_in.no_op = 1'b1;
        wait_cycles = 0;
        while (got_q.size() < exp_q.size()) begin
            if (wait_cycles >= DRAIN_LIMIT) begin
                $display("timed out waiting for writebacks, %0d of %0d arrived",
                         got_q.size(), exp_q.size());
                fail_now();
            end
            @(posedge clk);
            wait_cycles++;
        end
        repeat (4) @(posedge clk);              // room for a stray duplicate
        if (got_q.size() != exp_q.size()) begin
            $display("wb_out gave %0d writebacks where %0d were expected",
                     got_q.size(), exp_q.size());
            fail_now();
        end else begin
            foreach (exp_q[k]) begin
                compare_word($sformatf("wb_out.dest #%0d", k),
                             32'(got_q[k].dest), 32'(exp_q[k].dest));
                compare_word($sformatf("wb_out.data #%0d", k),
                             got_q[k].data, exp_q[k].data);
            end
            compare_word("dmem0.wr_en cycles", 32'(write_count), 32'(store_count));
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- testbench/backend_golden.txt
# i alu_op rs rt rs_val rt_val imm use_imm dest reg_write mem_read mem_write link pc_4 freeze stalls
# e dest data in retirement order; hex except freeze and stalls (decimal)
i 0 00 00 00000000 00000000 00000064 1 01 1 0 0 0 00400004 0 0
i 3 00 00 00000000 00000000 00000f0f 1 02 1 0 0 0 00400008 0 0
i 8 00 00 00000000 00000000 00001234 1 03 1 0 0 0 0040000c 0 0
i 0 00 00 00000000 00000000 fffffff6 1 04 1 0 0 0 00400010 0 0
i 1 01 02 00000064 00000f0f 00000000 0 05 1 0 0 0 00400014 0 0
i 5 04 01 fffffff6 00000064 00000000 0 06 1 0 0 0 00400018 0 0
i 7 04 00 fffffff6 00000000 00000004 1 07 1 0 0 0 0040001c 0 0
i 0 00 00 00000000 00000000 00000005 1 08 1 0 0 0 00400020 0 0
i 0 08 08 00000000 00000000 00000000 0 09 1 0 0 0 00400024 0 0
i 1 09 08 11111111 11111111 00000000 0 0a 1 0 0 0 00400028 0 0
i 0 00 00 00000000 00000000 00000100 1 08 1 0 0 0 0040002c 0 0
i 0 08 00 00000000 00000000 00000020 1 08 1 0 0 0 00400030 0 0
i 0 08 08 00000100 00000100 00000000 0 0b 1 0 0 0 00400034 0 0
i 0 00 00 00000000 00000000 00000040 1 0c 1 0 0 0 00400038 0 0
i 0 00 00 00000000 00000000 0000beef 1 0d 1 0 0 0 0040003c 0 0
i 0 0c 0d 00000000 00000000 00000000 1 00 0 0 1 0 00400040 0 0
i 0 0c 00 00000040 00000000 00000000 1 0e 1 1 0 0 00400044 0 0
i 0 0e 0d 00000000 0000beef 00000000 0 0f 1 0 0 0 00400048 0 1
i 0 0c 0f 00000040 00000000 00000004 1 00 0 0 1 0 0040004c 0 0
i 0 0c 00 00000040 00000000 00000004 1 10 1 1 0 0 00400050 3 0
i 1 10 01 00000000 00000064 00000000 0 11 1 0 0 0 00400054 2 1
i 9 00 00 00000000 00000000 00000000 1 1f 1 0 0 1 00400058 0 0
i 0 1f 00 00000000 00000000 00000008 1 12 1 0 0 0 0040005c 0 0
i 0 00 00 00000000 00000000 00000055 1 00 1 0 0 0 00400060 0 0
i 0 00 1f 00000000 00400058 00000000 0 13 1 0 0 0 00400064 0 0
e 01 00000064
e 02 00000f0f
e 03 12340000
e 04 fffffff6
e 05 fffff155
e 06 00000001
e 07 0fffffff
e 08 00000005
e 09 0000000a
e 0a 00000005
e 08 00000100
e 08 00000120
e 0b 00000240
e 0c 00000040
e 0d 0000beef
e 0e 0000beef
e 0f 00017dde
e 10 00017dde
e 11 00017d7a
e 1f 00400058
e 12 00400060
e 13 00400058

//--- src.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/alu.sv
logic/forwarding_unit.sv
logic/hazard_unit.sv
logic/ex_mem_reg.sv
logic/data_mem.sv
logic/mem_wb_reg.sv
logic/exec_backend.sv
testbench/tb_exec_backend.sv

//--- run.sh
#!/bin/sh
# build and run the exec_backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_exec_backend -f src.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_exec_backend)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
